/* hw/fsm_lab_cfg.svh */
`ifndef FSM_LAB_CFG_SVH
`define FSM_LAB_CFG_SVH

// Stable-time counter width of the key and switch filters.
`define FSM_LAB_DEBOUNCE_DEPTH 8

// Timer widths, a strobe every 2**W cycles.
`define FSM_LAB_SHIFT_STROBE_W 23
`define FSM_LAB_SEG_STROBE_W   10

// Bit-stream shift register, one bit per LED.
`define FSM_LAB_SHIFT_LEN 12

// Length of the 1-0-1 pattern the detectors look for.
`define FSM_LAB_PATTERN_LEN 3

`endif

/* hw/fsm_lab_pkg.sv */
`include "fsm_lab_cfg.svh"

package fsm_lab_pkg;

    typedef logic [3:0]                    key_t;           // Debounced keys.
    typedef logic [7:0]                    sw_t;            // Debounced switches and dot mask.
    typedef logic [`FSM_LAB_SHIFT_LEN-1:0] shift_t;
    typedef logic [15:0]                   strobe_count_t;
    typedef logic [7:0]                    event_count_t;

    // Moore detector, one state per pattern prefix plus the full match.
    typedef enum logic [$clog2(`FSM_LAB_PATTERN_LEN + 1)-1:0] {
        MOORE_IDLE,
        MOORE_GOT_1,
        MOORE_GOT_10,
        MOORE_GOT_101
    } moore_state_t;

    // Mealy detector needs no match state.
    typedef enum logic [$clog2(`FSM_LAB_PATTERN_LEN)-1:0] {
        MEALY_IDLE,
        MEALY_GOT_1,
        MEALY_GOT_10
    } mealy_state_t;

    // Laid out as shown, strobes on the left four digits.
    typedef struct packed {
        strobe_count_t strobes;
        event_count_t  moore_hits;
        event_count_t  mealy_hits;
    } stream_counts_t;

    // Board segment drive, all active low.
    typedef struct packed {
        logic [6:0] abcdefg;
        logic       dot;
    } seg_drive_t;

endpackage

/* hw/sync_and_debounce.sv */
`timescale 1ns/1ps
`include "fsm_lab_cfg.svh"

module sync_and_debounce #(
    parameter int W     = 1,
    parameter int DEPTH = `FSM_LAB_DEBOUNCE_DEPTH
) (
    input  logic         i_clk,
    input  logic         i_reset,
    input  logic [W-1:0] i_raw,
    output logic [W-1:0] o_clean
);

    logic [W-1:0]     meta_q;        // First synchronizer stage.
    logic [W-1:0]     sync_q;        // Safe to use from here on.
    logic [DEPTH-1:0] stable_cnt_q;
    logic             saturated;

    assign saturated = &stable_cnt_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= i_raw;
            sync_q <= meta_q;
        end
    end

    // One counter for the whole vector.
    // Any bit that differs from the output keeps it running.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            stable_cnt_q <= '0;
            o_clean      <= '0;
        end else if (sync_q == o_clean) begin
            stable_cnt_q <= '0;          // Nothing pending.
        end else if (saturated) begin
            stable_cnt_q <= '0;
            o_clean      <= sync_q;      // Held long enough.
        end else begin
            stable_cnt_q <= stable_cnt_q + 1'b1;
        end
    end

    // A change on the output needs a full stable window before it.
    assert property (@(posedge i_clk) disable iff (i_reset)
        o_clean != $past(o_clean) |-> $past(saturated));

endmodule

/* hw/strobe_gen.sv */
`timescale 1ns/1ps
`include "fsm_lab_cfg.svh"

module strobe_gen #(
    parameter int W = `FSM_LAB_SHIFT_STROBE_W
) (
    input  logic i_clk,
    input  logic i_reset,
    output logic o_strobe
);

    logic [W-1:0] count_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            count_q  <= '0;
            o_strobe <= 1'b0;
        end else begin
            count_q  <= count_q + 1'b1;
            // Set one step early so the strobe lines up with all ones.
            o_strobe <= (count_q == {{(W - 1){1'b1}}, 1'b0});
        end
    end

    // Consumers act once per strobe, so it must stay one cycle wide.
    assert property (@(posedge i_clk) disable iff (i_reset)
        o_strobe |=> !o_strobe);

endmodule

/* hw/bit_stream_stats.sv */
`timescale 1ns/1ps
`include "fsm_lab_cfg.svh"

module bit_stream_stats (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_shift_strobe,
    input  logic                        i_key_bit,
    input  logic                        i_moore_y,
    input  logic                        i_mealy_y,
    output fsm_lab_pkg::shift_t         o_led,
    output logic                        o_oldest_bit,
    output fsm_lab_pkg::stream_counts_t o_counts
);

    fsm_lab_pkg::shift_t         shift_q;
    fsm_lab_pkg::stream_counts_t counts_q;

    // New samples enter at the top and age toward bit 0.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            shift_q <= '0;
        end else if (i_shift_strobe) begin
            shift_q <= {i_key_bit, shift_q[`FSM_LAB_SHIFT_LEN-1:1]};
        end
    end

    // Wrapping counters, all sampled on the same strobe.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            counts_q <= '0;
        end else if (i_shift_strobe) begin
            counts_q.strobes <= counts_q.strobes + 1'b1;
            if (i_moore_y) begin
                counts_q.moore_hits <= counts_q.moore_hits + 1'b1;
            end
            if (i_mealy_y) begin
                counts_q.mealy_hits <= counts_q.mealy_hits + 1'b1;
            end
        end
    end

    assign o_led        = shift_q;
    assign o_oldest_bit = shift_q[0];    // Sample from twelve strobes ago.
    assign o_counts     = counts_q;

endmodule

/* hw/moore_101_detector.sv */
`timescale 1ns/1ps

module moore_101_detector (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_strobe,
    input  logic i_bit,
    output logic o_match
);

    fsm_lab_pkg::moore_state_t state_q;
    fsm_lab_pkg::moore_state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            fsm_lab_pkg::MOORE_IDLE: begin
                if (i_bit) state_d = fsm_lab_pkg::MOORE_GOT_1;
            end
            fsm_lab_pkg::MOORE_GOT_1: begin
                if (!i_bit) state_d = fsm_lab_pkg::MOORE_GOT_10;
            end
            fsm_lab_pkg::MOORE_GOT_10: begin
                state_d = i_bit ? fsm_lab_pkg::MOORE_GOT_101 : fsm_lab_pkg::MOORE_IDLE;
            end
            fsm_lab_pkg::MOORE_GOT_101: begin
                // Trailing 1 of the match starts the next one.
                state_d = i_bit ? fsm_lab_pkg::MOORE_GOT_1 : fsm_lab_pkg::MOORE_GOT_10;
            end
            default: state_d = fsm_lab_pkg::MOORE_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q <= fsm_lab_pkg::MOORE_IDLE;
        end else if (i_strobe) begin
            state_q <= state_d;
        end
    end

    // Held for the whole strobe period after the match.
    assign o_match = (state_q == fsm_lab_pkg::MOORE_GOT_101);

    // A match never outlasts the strobe that follows it.
    assert property (@(posedge i_clk) disable iff (i_reset)
        (o_match && i_strobe) |=> !o_match);

endmodule

/* hw/mealy_101_detector.sv */
`timescale 1ns/1ps

module mealy_101_detector (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_strobe,
    input  logic i_bit,
    output logic o_match
);

    fsm_lab_pkg::mealy_state_t state_q;
    fsm_lab_pkg::mealy_state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            fsm_lab_pkg::MEALY_IDLE: begin
                if (i_bit) state_d = fsm_lab_pkg::MEALY_GOT_1;
            end
            fsm_lab_pkg::MEALY_GOT_1: begin
                if (!i_bit) state_d = fsm_lab_pkg::MEALY_GOT_10;
            end
            fsm_lab_pkg::MEALY_GOT_10: begin
                // On a match the last 1 already counts as a new prefix.
                state_d = i_bit ? fsm_lab_pkg::MEALY_GOT_1 : fsm_lab_pkg::MEALY_IDLE;
            end
            default: state_d = fsm_lab_pkg::MEALY_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q <= fsm_lab_pkg::MEALY_IDLE;
        end else if (i_strobe) begin
            state_q <= state_d;
        end
    end

    // Only valid in the strobe cycle that completes the pattern.
    assign o_match = i_strobe && i_bit && (state_q == fsm_lab_pkg::MEALY_GOT_10);

    // Overlapping matches need the trailing 1 kept as a prefix.
    assert property (@(posedge i_clk) disable iff (i_reset)
        o_match |=> (state_q == fsm_lab_pkg::MEALY_GOT_1));

endmodule

/* hw/seven_segment_scan.sv */
`timescale 1ns/1ps

module seven_segment_scan (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_scan_strobe,
    input  fsm_lab_pkg::stream_counts_t i_value,
    input  fsm_lab_pkg::sw_t            i_dots,
    output fsm_lab_pkg::seg_drive_t     o_seg,
    output logic [7:0]                  o_digit
);

    logic [2:0]  index_q;     // Digit being driven.
    logic [31:0] value_bits;
    logic [3:0]  nibble;

    // Segments a to g, lit bits high.
    function automatic logic [6:0] hex_segments(input logic [3:0] hex);
        case (hex)
            4'h0:    return 7'b1111110;
            4'h1:    return 7'b0110000;
            4'h2:    return 7'b1101101;
            4'h3:    return 7'b1111001;
            4'h4:    return 7'b0110011;
            4'h5:    return 7'b1011011;
            4'h6:    return 7'b1011111;
            4'h7:    return 7'b1110000;
            4'h8:    return 7'b1111111;
            4'h9:    return 7'b1111011;
            4'ha:    return 7'b1110111;
            4'hb:    return 7'b0011111;
            4'hc:    return 7'b1001110;
            4'hd:    return 7'b0111101;
            4'he:    return 7'b1001111;
            default: return 7'b1000111;    // F.
        endcase
    endfunction

    assign value_bits = i_value;
    assign nibble     = value_bits[{index_q, 2'b00} +: 4];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            index_q <= '0;
        end else if (i_scan_strobe) begin
            index_q <= index_q + 1'b1;    // Wraps after digit 7.
        end
    end

    // Outputs follow the index one cycle later.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_seg.abcdefg <= '1;          // Blank.
            o_seg.dot     <= 1'b1;
            o_digit       <= 8'hfe;
        end else begin
            o_seg.abcdefg <= ~hex_segments(nibble);
            o_seg.dot     <= ~i_dots[index_q];
            o_digit       <= ~(8'h01 << index_q);
        end
    end

    // Two anodes low at once would show one digit on both.
    assert property (@(posedge i_clk) disable iff (i_reset)
        $onehot(~o_digit));

endmodule

/* hw/fsm_lab.sv */
`timescale 1ns/1ps
`include "fsm_lab_cfg.svh"

module fsm_lab #(
    parameter int DEBOUNCE_DEPTH = `FSM_LAB_DEBOUNCE_DEPTH,
    parameter int SHIFT_STROBE_W = `FSM_LAB_SHIFT_STROBE_W,
    parameter int SEG_STROBE_W   = `FSM_LAB_SEG_STROBE_W
) (
    input  logic                    clk,
    input  logic                    i_reset,
    input  fsm_lab_pkg::key_t       i_key,
    input  fsm_lab_pkg::sw_t        i_sw,
    output fsm_lab_pkg::shift_t     o_led,
    output fsm_lab_pkg::seg_drive_t o_seg,
    output logic [7:0]              o_digit
);

    fsm_lab_pkg::key_t           key_db;
    fsm_lab_pkg::sw_t            sw_db;
    logic                        shift_strobe;
    logic                        scan_strobe;
    logic                        oldest_bit;
    logic                        moore_y;
    logic                        mealy_y;
    fsm_lab_pkg::stream_counts_t counts;

    sync_and_debounce #(.W($bits(fsm_lab_pkg::key_t)), .DEPTH(DEBOUNCE_DEPTH)) key_db_inst (
        .i_clk   (clk),
        .i_reset (i_reset),
        .i_raw   (i_key),
        .o_clean (key_db)
    );

    sync_and_debounce #(.W($bits(fsm_lab_pkg::sw_t)), .DEPTH(DEBOUNCE_DEPTH)) sw_db_inst (
        .i_clk   (clk),
        .i_reset (i_reset),
        .i_raw   (i_sw),
        .o_clean (sw_db)
    );

    strobe_gen #(.W(SHIFT_STROBE_W)) shift_strobe_inst (
        .i_clk    (clk),
        .i_reset  (i_reset),
        .o_strobe (shift_strobe)
    );

    // Key 1 is the bit source.
    bit_stream_stats stats_inst (
        .i_clk          (clk),
        .i_reset        (i_reset),
        .i_shift_strobe (shift_strobe),
        .i_key_bit      (key_db[1]),
        .i_moore_y      (moore_y),
        .i_mealy_y      (mealy_y),
        .o_led          (o_led),
        .o_oldest_bit   (oldest_bit),
        .o_counts       (counts)
    );

    moore_101_detector moore_inst (
        .i_clk    (clk),
        .i_reset  (i_reset),
        .i_strobe (shift_strobe),
        .i_bit    (oldest_bit),
        .o_match  (moore_y)
    );

    mealy_101_detector mealy_inst (
        .i_clk    (clk),
        .i_reset  (i_reset),
        .i_strobe (shift_strobe),
        .i_bit    (oldest_bit),
        .o_match  (mealy_y)
    );

    strobe_gen #(.W(SEG_STROBE_W)) scan_strobe_inst (
        .i_clk    (clk),
        .i_reset  (i_reset),
        .o_strobe (scan_strobe)
    );

    seven_segment_scan scan_inst (
        .i_clk         (clk),
        .i_reset       (i_reset),
        .i_scan_strobe (scan_strobe),
        .i_value       (counts),
        .i_dots        (sw_db),      // Switches light the dots.
        .o_seg         (o_seg),
        .o_digit       (o_digit)
    );

endmodule

/* bench/tb_fsm_lab.sv */
`timescale 1ns/1ps

module tb_fsm_lab;

    localparam int SHIFT_W        = 6;
    localparam int STROBE_PERIOD  = 1 << SHIFT_W;
    localparam int STROBE_PHASE   = STROBE_PERIOD - 1;   // Cycle in which the strobe acts.
    localparam int MID_PHASE      = STROBE_PERIOD / 2 - 1;
    localparam int SHIFT_LEN      = $bits(fsm_lab_pkg::shift_t);
    localparam int TIMEOUT_CYCLES = 12000;               // About 140 periods plus margin.

    // Lit segments a to g for the hex digits 0 to F.
    localparam logic [6:0] SEG_TABLE [16] = '{
        7'h7e, 7'h30, 7'h6d, 7'h79, 7'h33, 7'h5b, 7'h5f, 7'h70,
        7'h7f, 7'h7b, 7'h77, 7'h1f, 7'h4e, 7'h3d, 7'h4f, 7'h47
    };

    logic                    clk;
    logic                    i_reset;
    fsm_lab_pkg::key_t       i_key;
    fsm_lab_pkg::sw_t        i_sw;
    fsm_lab_pkg::shift_t     o_led;
    fsm_lab_pkg::seg_drive_t o_seg;
    logic [7:0]              o_digit;

    int                          cyc;            // Cycles since reset release.
    logic                        key_level;      // Level key 1 settles to.
    fsm_lab_pkg::sw_t            sw_level;
    fsm_lab_pkg::shift_t         model_shift;
    logic [2:0]                  model_hist;     // Last three bits fed to the detectors.
    logic                        moore_pending;
    fsm_lab_pkg::event_count_t   model_moore;
    fsm_lab_pkg::event_count_t   model_mealy;

    fsm_lab #(
        .DEBOUNCE_DEPTH (2),
        .SHIFT_STROBE_W (SHIFT_W),
        .SEG_STROBE_W   (2)
    ) fsm_lab_inst (
        .clk     (clk),
        .i_reset (i_reset),
        .i_key   (i_key),
        .i_sw    (i_sw),
        .o_led   (o_led),
        .o_seg   (o_seg),
        .o_digit (o_digit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else
            stop_with_failure($sformatf("Mismatch at %0t ns: %s got %0h, expected %0h",
                                        $time, name, got, expected));
    endtask

    // One strobe of the reference model.
    task automatic update_model();
        logic fed;
        fed = model_shift[0];
        if (moore_pending) begin
            model_moore = model_moore + 8'd1;    // Moore lags by one strobe.
        end
        model_hist    = {model_hist[1:0], fed};
        moore_pending = (model_hist == 3'b101);
        if (model_hist == 3'b101) begin
            model_mealy = model_mealy + 8'd1;
        end
        model_shift = {key_level, model_shift[SHIFT_LEN-1:1]};
    endtask

    always @(posedge clk) begin
        if (i_reset) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
            if (cyc % STROBE_PERIOD == STROBE_PHASE) begin
                update_model();
            end
        end
    end

    initial begin
        wait (cyc >= TIMEOUT_CYCLES);
        stop_with_failure("Timeout: the tests did not finish within the cycle limit.");
    end

    // Returns at the rising edge whose cycle number has the given phase.
    task automatic wait_cycle_phase(input int phase);
        do begin
            @(posedge clk);
        end while (cyc % STROBE_PERIOD != phase);
    endtask

    task automatic read_display(output logic [31:0] value, output logic [7:0] dots);
        logic [6:0] lit;
        logic       found;
        for (int i = 0; i < 8; i++) begin
            do begin
                @(negedge clk);
            end while (o_digit !== ~(8'h01 << i));
            lit   = ~o_seg.abcdefg;
            found = 1'b0;
            for (int h = 0; h < 16; h++) begin
                if (SEG_TABLE[h] == lit) begin
                    value[4*i +: 4] = 4'(h);
                    found           = 1'b1;
                end
            end
            assert (found) else
                stop_with_failure($sformatf("Digit %0d shows no hex pattern.", i));
            dots[i] = ~o_seg.dot;
        end
    endtask

    // Call right after a strobe, the whole scan fits before the next one.
    task automatic compare_display();
        logic [31:0] shown;
        logic [7:0]  dots;
        logic [15:0] strobes;
        strobes = 16'(cyc / STROBE_PERIOD);
        read_display(shown, dots);
        check_value("display strobes", 32'(shown[31:16]), 32'(strobes));
        check_value("display moore_hits", 32'(shown[15:8]), 32'(model_moore));
        check_value("display mealy_hits", 32'(shown[7:0]), 32'(model_mealy));
        check_value("display dots", 32'(dots), 32'(sw_level));
    endtask

    // Key change halfway through, o_led checked after the strobe.
    task automatic run_period(input logic b);
        wait_cycle_phase(MID_PHASE);
        i_key[1] <= b;
        key_level = b;
        wait_cycle_phase(STROBE_PHASE);
        @(negedge clk);
        check_value("o_led", 32'(o_led), 32'(model_shift));
    endtask

    task automatic verify_reset_state();
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("o_led", 32'(o_led), 32'h0);
        compare_display();
    endtask

    task automatic shift_fixed_sequence();
        logic [11:0] seq;
        seq = 12'b1011_0011_1010;
        for (int i = 11; i >= 0; i--) begin
            run_period(seq[i]);
        end
    endtask

    task automatic count_random_matches();
        logic [31:0] rnd;
        for (int n = 0; n < 60; n++) begin
            rnd = $urandom;
            run_period(rnd[0]);
            if (n % 20 == 19) begin
                compare_display();
            end
        end
        // Flush the last bits through to the detectors.
        for (int n = 0; n < SHIFT_LEN + 2; n++) begin
            run_period(1'b0);
        end
        compare_display();
        assert (model_mealy != 0) else
            stop_with_failure("The random stream held no 1-0-1 pattern.");
    endtask

    task automatic light_switch_dots();
        for (int n = 0; n < 4; n++) begin
            wait_cycle_phase(MID_PHASE);
            sw_level = fsm_lab_pkg::sw_t'($urandom);
            i_sw <= sw_level;
            wait_cycle_phase(STROBE_PHASE);
            @(negedge clk);
            compare_display();
        end
    endtask

    task automatic reject_short_pulse();
        for (int n = 0; n < 2; n++) begin
            run_period(n[0]);
            // Late in the period, a pulse that got through would be sampled.
            wait_cycle_phase(STROBE_PERIOD - 8);
            i_key[1] <= ~key_level;           // Too short for the filter.
            repeat (3) @(posedge clk);
            i_key[1] <= key_level;
            run_period(key_level);
            compare_display();
        end
    endtask

    initial begin
        void'($urandom(32'h48af));
        i_reset       = 1'b1;
        i_key         = '0;
        i_sw          = '0;
        key_level     = 1'b0;
        sw_level      = '0;
        model_shift   = '0;
        model_hist    = '0;
        moore_pending = 1'b0;
        model_moore   = '0;
        model_mealy   = '0;
        repeat (8) @(posedge clk);
        i_reset <= 1'b0;

        verify_reset_state();
        shift_fixed_sequence();
        count_random_matches();
        light_switch_dots();
        reject_short_pulse();

        $display(">>> PASS");
        $finish;
    end

endmodule

/* fsm_lab.f */
+incdir+hw
hw/fsm_lab_pkg.sv
hw/sync_and_debounce.sv
hw/strobe_gen.sv
hw/bit_stream_stats.sv
hw/moore_101_detector.sv
hw/mealy_101_detector.sv
hw/seven_segment_scan.sv
hw/fsm_lab.sv
bench/tb_fsm_lab.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f fsm_lab.f --top-module tb_fsm_lab -o tb_fsm_lab
	out=$$(./obj_dir/tb_fsm_lab); \
	echo "$$out"; \
	echo "$$out" | grep -qF '>>> PASS'

clean:
	rm -rf obj_dir
